// File: logic/rob_pkg.sv
package rob_pkg;

  // ----------------------------------------
  // buffer geometry
  // ----------------------------------------
  localparam int DISP_SIZE   = 2;                 // lanes per dispatch group
  localparam int ROB_ENTRIES = 8;                 // groups in flight
  localparam int ENTRY_W     = $clog2(ROB_ENTRIES);
  localparam int CMT_ID_W    = ENTRY_W + 1;       // index plus wrap bit
  localparam int DONE_PORTS  = 2;
  localparam int LANE_W      = $clog2(DISP_SIZE);

  localparam int PC_W       = 16;
  localparam int LANE_BYTES = 4;                  // pc step from one lane to the next

  // ----------------------------------------
  // completion payload
  // ----------------------------------------
  localparam int CAUSE_W = 4;
  localparam int INFO_W  = 16;
  localparam int TVAL_W  = INFO_W - CAUSE_W;      // 12 bits of trap value
  localparam int TGT_W   = INFO_W - 2;            // halfword target

  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = 4'd2;

  // one report word, read as exception or as branch result
  // kind = 0 selects exc, kind = 1 selects br
  typedef union packed {
    struct packed {
      logic [CAUSE_W-1:0] cause;
      logic [TVAL_W-1:0]  tval;
    } exc;
    struct packed {
      logic             mispredict;
      logic             taken;
      logic [TGT_W-1:0] target;
    } br;
  } rpt_info_u;

endpackage

// File: logic/rob_ifs.sv
`timescale 1ns/1ps

// dispatch group as it is written into one entry
interface rob_load_if;
  import rob_pkg::*;

  logic [ROB_ENTRIES-1:0] load_valid;             // one-hot target entry
  logic                   load_wrap;
  logic [DISP_SIZE-1:0]   grp_id;
  logic [PC_W-1:0]        pc;
  logic [DISP_SIZE-1:0]   except_valid;
  logic [CAUSE_W-1:0]     except_cause [DISP_SIZE];
  logic [DISP_SIZE-1:0]   dead;

  modport alloc (output load_valid, load_wrap, grp_id, pc, except_valid, except_cause, dead);
  modport entry (input  load_valid, load_wrap, grp_id, pc, except_valid, except_cause, dead);
endinterface

// execution-done reports, one slot per completion port
interface rob_done_if;
  import rob_pkg::*;

  logic [DONE_PORTS-1:0] valid;
  logic [CMT_ID_W-1:0]   cmt_id [DONE_PORTS];
  logic [LANE_W-1:0]     lane   [DONE_PORTS];
  logic [DONE_PORTS-1:0] kind;
  logic [DONE_PORTS-1:0] exc;
  rpt_info_u             info   [DONE_PORTS];

  modport src   (output valid, cmt_id, lane, kind, exc, info);
  modport entry (input  valid, cmt_id, lane, kind, exc, info);
endinterface

// per-entry state towards the commit side, release and kill back
interface rob_view_if;
  import rob_pkg::*;

  logic                 valid        [ROB_ENTRIES];
  logic [DISP_SIZE-1:0] grp_id       [ROB_ENTRIES];
  logic [DISP_SIZE-1:0] done_grp_id  [ROB_ENTRIES];
  logic [DISP_SIZE-1:0] dead         [ROB_ENTRIES];
  logic [DISP_SIZE-1:0] except_valid [ROB_ENTRIES];
  logic [CAUSE_W-1:0]   cause        [ROB_ENTRIES][DISP_SIZE];
  logic [TVAL_W-1:0]    tval         [ROB_ENTRIES][DISP_SIZE];
  logic [DISP_SIZE-1:0] mispredict   [ROB_ENTRIES];
  logic [TGT_W-1:0]     target       [ROB_ENTRIES][DISP_SIZE];
  logic [PC_W-1:0]      pc           [ROB_ENTRIES];

  logic [ROB_ENTRIES-1:0] release_en;
  logic                   kill;

  modport entry (output valid, grp_id, done_grp_id, dead, except_valid, cause, tval,
                        mispredict, target, pc,
                 input  release_en, kill);
  modport commit (input  valid, grp_id, done_grp_id, dead, except_valid, cause, tval,
                         mispredict, target, pc,
                  output release_en, kill);
endinterface

// File: logic/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_disp_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_grp_id,
  input  logic [rob_pkg::PC_W-1:0]      i_disp_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_illegal,
  input  logic                          i_flush,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_new_cmt_id,
  rob_load_if.alloc                     load
);
  import rob_pkg::*;

  logic [CMT_ID_W-1:0] r_alloc_id;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_id <= '0;
    end else if (i_disp_valid) begin
      r_alloc_id <= r_alloc_id + 1'b1;  // wrap bit toggles every lap
    end
  end

  assign o_new_cmt_id = r_alloc_id;

  // one-hot write strobe for the slot under the pointer
  always_comb begin
    load.load_valid = '0;
    if (i_disp_valid) begin
      load.load_valid[r_alloc_id[ENTRY_W-1:0]] = 1'b1;
    end
  end

  assign load.load_wrap    = r_alloc_id[ENTRY_W];
  assign load.grp_id       = i_disp_grp_id;
  assign load.pc           = i_disp_pc;
  assign load.except_valid = i_disp_grp_id & i_disp_illegal;
  assign load.dead         = i_flush ? i_disp_grp_id : '0;  // dispatched under a flush

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      load.except_cause[d] = load.except_valid[d] ? CAUSE_ILLEGAL : '0;
    end
  end

endmodule

// File: logic/rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic       i_clk,
  input  logic       i_reset_n,
  rob_load_if.entry  load,
  rob_done_if.entry  done,
  rob_view_if.entry  view
);
  import rob_pkg::*;

  localparam logic [ENTRY_W-1:0] IDX = ENTRY_W'(ENTRY_IDX);

  // control state
  logic                 r_valid;
  logic [DISP_SIZE-1:0] r_done;
  logic [DISP_SIZE-1:0] r_dead;
  logic [DISP_SIZE-1:0] r_except;
  logic [DISP_SIZE-1:0] r_mispred;

  // payload
  logic                 r_wrap;
  logic [DISP_SIZE-1:0] r_grp_id;
  logic [PC_W-1:0]      r_pc;
  logic [CAUSE_W-1:0]   r_cause  [DISP_SIZE];
  logic [TVAL_W-1:0]    r_tval   [DISP_SIZE];
  logic [TGT_W-1:0]     r_target [DISP_SIZE];

  logic [CMT_ID_W-1:0]   w_my_id;
  logic [DONE_PORTS-1:0] w_port_exc;
  logic [DONE_PORTS-1:0] w_port_mp;
  logic [DISP_SIZE-1:0]  w_rpt_done;
  logic [DISP_SIZE-1:0]  w_rpt_exc;
  logic [DISP_SIZE-1:0]  w_rpt_mp;

  assign w_my_id = {r_wrap, IDX};

  // ----------------------------------------
  // report matching
  // ----------------------------------------
  always_comb begin
    w_port_exc = '0;
    w_port_mp  = '0;
    w_rpt_done = '0;
    w_rpt_exc  = '0;
    w_rpt_mp   = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      // full id compare keeps an older lap from hitting this slot
      if (r_valid && done.valid[p] && (done.cmt_id[p] == w_my_id)) begin
        w_port_exc[p] = !done.kind[p] && done.exc[p];
        w_port_mp[p]  = done.kind[p] && done.info[p].br.mispredict;
        w_rpt_done[done.lane[p]] = 1'b1;
        if (w_port_exc[p]) begin
          w_rpt_exc[done.lane[p]] = 1'b1;
        end
        if (w_port_mp[p]) begin
          w_rpt_mp[done.lane[p]] = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // state update
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= 1'b0;
      r_done    <= '0;
      r_dead    <= '0;
      r_except  <= '0;
      r_mispred <= '0;
    end else begin
      if (view.release_en[ENTRY_IDX]) begin
        r_valid   <= 1'b0;
        r_done    <= '0;
        r_dead    <= '0;
        r_except  <= '0;
        r_mispred <= '0;
      end else if (r_valid && view.kill) begin
        r_done <= r_grp_id;  // drains as an all-dead group
        r_dead <= r_grp_id;
      end else if (r_valid) begin
        r_done    <= r_done | w_rpt_done;
        r_except  <= r_except | w_rpt_exc;
        r_mispred <= r_mispred | w_rpt_mp;
      end

      // reuse of the slot wins over its release
      if (load.load_valid[ENTRY_IDX]) begin
        r_valid   <= 1'b1;
        r_done    <= load.except_valid | load.dead;
        r_dead    <= load.dead;
        r_except  <= load.except_valid;
        r_mispred <= '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (load.load_valid[ENTRY_IDX]) begin
      r_wrap   <= load.load_wrap;
      r_grp_id <= load.grp_id;
      r_pc     <= load.pc;
      for (int d = 0; d < DISP_SIZE; d++) begin
        r_cause[d]  <= load.except_cause[d];
        r_tval[d]   <= '0;  // illegal instruction carries no trap value
        r_target[d] <= '0;
      end
    end else begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (w_port_exc[p]) begin
          r_cause[done.lane[p]] <= done.info[p].exc.cause;
          r_tval[done.lane[p]]  <= done.info[p].exc.tval;
        end
        if (w_port_mp[p]) begin
          r_target[done.lane[p]] <= done.info[p].br.target;
        end
      end
    end
  end

  assign view.valid[ENTRY_IDX]        = r_valid;
  assign view.grp_id[ENTRY_IDX]       = r_grp_id;
  assign view.done_grp_id[ENTRY_IDX]  = r_done;
  assign view.dead[ENTRY_IDX]         = r_dead;
  assign view.except_valid[ENTRY_IDX] = r_except;
  assign view.cause[ENTRY_IDX]        = r_cause;
  assign view.tval[ENTRY_IDX]         = r_tval;
  assign view.mispredict[ENTRY_IDX]   = r_mispred;
  assign view.target[ENTRY_IDX]       = r_target;
  assign view.pc[ENTRY_IDX]           = r_pc;

endmodule

// File: logic/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  rob_view_if.commit                    view,
  output logic                          o_cmt_valid,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_cmt_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_grp_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_dead_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_except_valid,
  output logic [rob_pkg::CAUSE_W-1:0]   o_cmt_except_cause,
  output logic [rob_pkg::TVAL_W-1:0]    o_cmt_tval,
  output logic [rob_pkg::PC_W-1:0]      o_cmt_epc,
  output logic                          o_cmt_flush,
  output logic [rob_pkg::PC_W-1:0]      o_cmt_redirect_pc
);
  import rob_pkg::*;

  logic [CMT_ID_W-1:0]  r_cmt_id;
  logic [ENTRY_W-1:0]   w_head;
  logic [DISP_SIZE-1:0] w_grp;
  logic [DISP_SIZE-1:0] w_dead;
  logic [DISP_SIZE-1:0] w_exc;
  logic [DISP_SIZE-1:0] w_redirect;
  logic [DISP_SIZE-1:0] w_younger;
  logic                 w_all_done;
  logic                 w_sel_found;
  logic [LANE_W-1:0]    w_sel_idx;
  logic                 w_sel_exc;

  // ----------------------------------------
  // head entry
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cmt_id <= '0;
    end else if (o_cmt_valid) begin
      r_cmt_id <= r_cmt_id + 1'b1;
    end
  end

  assign w_head     = r_cmt_id[ENTRY_W-1:0];
  assign w_grp      = view.grp_id[w_head];
  assign w_dead     = view.dead[w_head];
  assign w_exc      = view.except_valid[w_head];
  assign w_all_done = (view.done_grp_id[w_head] & w_grp) == w_grp;

  assign o_cmt_valid  = view.valid[w_head] && w_all_done;
  assign o_cmt_id     = r_cmt_id;
  assign o_cmt_grp_id = w_grp;

  // ----------------------------------------
  // redirect lane selection
  // ----------------------------------------
  assign w_redirect = (w_exc | view.mispredict[w_head]) & ~w_dead & w_grp;

  always_comb begin
    w_sel_found = 1'b0;
    w_sel_idx   = '0;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin  // lowest lane wins
      if (w_redirect[d]) begin
        w_sel_found = 1'b1;
        w_sel_idx   = LANE_W'(d);
      end
    end
  end

  // everything behind the redirecting lane is squashed
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_younger[d] = w_sel_found && (d > int'(w_sel_idx));
    end
  end

  assign w_sel_exc = w_sel_found && w_exc[w_sel_idx];  // exception beats mispredict

  assign o_cmt_dead_id      = (w_dead | w_younger) & w_grp;
  assign o_cmt_flush        = o_cmt_valid && w_sel_found;
  assign o_cmt_except_valid = (o_cmt_valid && w_sel_exc) ?
                              DISP_SIZE'(1) << w_sel_idx : '0;
  assign o_cmt_except_cause = view.cause[w_head][w_sel_idx];
  assign o_cmt_tval         = view.tval[w_head][w_sel_idx];
  assign o_cmt_epc          = view.pc[w_head] + PC_W'(w_sel_idx * LANE_BYTES);

  // halfword target to byte address
  assign o_cmt_redirect_pc  = (o_cmt_flush && !w_sel_exc) ?
                              PC_W'({view.target[w_head][w_sel_idx], 1'b0}) : '0;

  // ----------------------------------------
  // release and kill towards the entries
  // ----------------------------------------
  always_comb begin
    view.release_en = '0;
    if (o_cmt_valid) begin
      view.release_en[w_head] = 1'b1;
    end
  end

  assign view.kill = o_cmt_flush;  // every other in-flight group goes dead

endmodule

// File: logic/rob_top.sv
`timescale 1ns/1ps

module rob_top (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  // dispatch
  input  logic                          i_disp_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_grp_id,
  input  logic [rob_pkg::PC_W-1:0]      i_disp_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_illegal,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_new_cmt_id,

  // completion ports
  input  logic [rob_pkg::DONE_PORTS-1:0] i_done_valid,
  input  logic [rob_pkg::CMT_ID_W-1:0]   i_done_cmt_id [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::LANE_W-1:0]     i_done_lane   [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::DONE_PORTS-1:0] i_done_kind,
  input  logic [rob_pkg::DONE_PORTS-1:0] i_done_exc,
  input  rob_pkg::rpt_info_u             i_done_info   [rob_pkg::DONE_PORTS],

  // commit
  output logic                          o_cmt_valid,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_cmt_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_grp_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_dead_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_except_valid,
  output logic [rob_pkg::CAUSE_W-1:0]   o_cmt_except_cause,
  output logic [rob_pkg::TVAL_W-1:0]    o_cmt_tval,
  output logic [rob_pkg::PC_W-1:0]      o_cmt_epc,
  output logic                          o_cmt_flush,
  output logic [rob_pkg::PC_W-1:0]      o_cmt_redirect_pc
);
  import rob_pkg::*;

  rob_load_if load_if ();
  rob_done_if done_if ();
  rob_view_if view_if ();

  assign done_if.valid  = i_done_valid;
  assign done_if.cmt_id = i_done_cmt_id;
  assign done_if.lane   = i_done_lane;
  assign done_if.kind   = i_done_kind;
  assign done_if.exc    = i_done_exc;
  assign done_if.info   = i_done_info;

  rob_alloc u_alloc (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_grp_id  (i_disp_grp_id),
    .i_disp_pc      (i_disp_pc),
    .i_disp_illegal (i_disp_illegal),
    .i_flush        (o_cmt_flush),  // new group dies with the flush
    .o_new_cmt_id   (o_new_cmt_id),
    .load           (load_if)
  );

  for (genvar e = 0; e < ROB_ENTRIES; e++) begin : g_entry
    rob_entry #(.ENTRY_IDX(e)) u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .load      (load_if),
      .done      (done_if),
      .view      (view_if)
    );
  end

  rob_commit u_commit (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .view               (view_if),
    .o_cmt_valid        (o_cmt_valid),
    .o_cmt_id           (o_cmt_id),
    .o_cmt_grp_id       (o_cmt_grp_id),
    .o_cmt_dead_id      (o_cmt_dead_id),
    .o_cmt_except_valid (o_cmt_except_valid),
    .o_cmt_except_cause (o_cmt_except_cause),
    .o_cmt_tval         (o_cmt_tval),
    .o_cmt_epc          (o_cmt_epc),
    .o_cmt_flush        (o_cmt_flush),
    .o_cmt_redirect_pc  (o_cmt_redirect_pc)
  );

endmodule

// File: test/rob_checker.sv
`timescale 1ns/1ps

module rob_checker (
  input logic                          i_clk,
  input logic                          i_reset_n,
  input logic                          i_disp_valid,
  input logic [rob_pkg::CMT_ID_W-1:0]  i_new_cmt_id,
  input logic                          i_cmt_valid,
  input logic [rob_pkg::CMT_ID_W-1:0]  i_cmt_id,
  input logic [rob_pkg::DISP_SIZE-1:0] i_cmt_grp_id,
  input logic [rob_pkg::DISP_SIZE-1:0] i_cmt_dead_id,
  input logic [rob_pkg::DISP_SIZE-1:0] i_cmt_except_valid,
  input logic                          i_cmt_flush
);
  import rob_pkg::*;

  logic [CMT_ID_W-1:0] w_in_flight;

  assign w_in_flight = i_new_cmt_id - i_cmt_id;  // groups allocated, not yet committed

  a_dead_in_grp: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cmt_valid |-> ((i_cmt_dead_id & ~i_cmt_grp_id) == '0))
    else $error("dead lanes outside the committing group");

  a_one_except: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_cmt_except_valid))
    else $error("more than one excepting lane at commit");

  a_flush_commit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cmt_flush |-> i_cmt_valid)
    else $error("flush without a commit");

  // no back-pressure, so the dispatcher has to hold off
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> (w_in_flight < CMT_ID_W'(ROB_ENTRIES)))
    else $error("dispatch into a full buffer");

endmodule

bind rob_top rob_checker u_checker (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_disp_valid       (i_disp_valid),
  .i_new_cmt_id       (o_new_cmt_id),
  .i_cmt_valid        (o_cmt_valid),
  .i_cmt_id           (o_cmt_id),
  .i_cmt_grp_id       (o_cmt_grp_id),
  .i_cmt_dead_id      (o_cmt_dead_id),
  .i_cmt_except_valid (o_cmt_except_valid),
  .i_cmt_flush        (o_cmt_flush)
);

// File: test/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
  import rob_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = 400;  // tests need about 150 cycles

  typedef struct packed {
    logic [CMT_ID_W-1:0]  id;
    logic [DISP_SIZE-1:0] grp;
    logic [DISP_SIZE-1:0] dead;
    logic [DISP_SIZE-1:0] exc;
    logic [CAUSE_W-1:0]   cause;
    logic [TVAL_W-1:0]    tval;
    logic [PC_W-1:0]      epc;
    logic                 flush;
    logic [PC_W-1:0]      redirect;
  } commit_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_disp_valid;
  logic [DISP_SIZE-1:0]  i_disp_grp_id;
  logic [PC_W-1:0]       i_disp_pc;
  logic [DISP_SIZE-1:0]  i_disp_illegal;
  logic [CMT_ID_W-1:0]   o_new_cmt_id;
  logic [DONE_PORTS-1:0] i_done_valid;
  logic [CMT_ID_W-1:0]   i_done_cmt_id [DONE_PORTS];
  logic [LANE_W-1:0]     i_done_lane   [DONE_PORTS];
  logic [DONE_PORTS-1:0] i_done_kind;
  logic [DONE_PORTS-1:0] i_done_exc;
  rpt_info_u             i_done_info   [DONE_PORTS];
  logic                  o_cmt_valid;
  logic [CMT_ID_W-1:0]   o_cmt_id;
  logic [DISP_SIZE-1:0]  o_cmt_grp_id;
  logic [DISP_SIZE-1:0]  o_cmt_dead_id;
  logic [DISP_SIZE-1:0]  o_cmt_except_valid;
  logic [CAUSE_W-1:0]    o_cmt_except_cause;
  logic [TVAL_W-1:0]     o_cmt_tval;
  logic [PC_W-1:0]       o_cmt_epc;
  logic                  o_cmt_flush;
  logic [PC_W-1:0]       o_cmt_redirect_pc;

  int                  errors;
  int                  checks;
  int                  cycles;
  int                  seed;
  string               cur_test;
  commit_t             exp_q [$];    // expected commits, oldest first
  logic [CMT_ID_W-1:0] next_id;      // model of the allocation pointer

  rob_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_val(input string what, input int exp, input int act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("mismatch %s %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  task automatic tick();
    @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  function automatic logic [PC_W-1:0] rand_pc();
    return PC_W'($random(seed) & 32'hfffc);  // word aligned group pc
  endfunction

  function automatic commit_t plain_commit(input logic [CMT_ID_W-1:0]  id,
                                           input logic [DISP_SIZE-1:0] grp,
                                           input logic [DISP_SIZE-1:0] dead);
    commit_t e;
    e      = '0;
    e.id   = id;
    e.grp  = grp;
    e.dead = dead;
    return e;
  endfunction

  task automatic clear_reports();
    i_done_valid = '0;
    i_done_kind  = '0;
    i_done_exc   = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_cmt_id[p] = '0;
      i_done_lane[p]   = '0;
      i_done_info[p]   = '0;
    end
  endtask

  task automatic dispatch(input logic [DISP_SIZE-1:0] grp, input logic [PC_W-1:0] pc,
                          input logic [DISP_SIZE-1:0] illegal,
                          output logic [CMT_ID_W-1:0] id);
    check_val("new_cmt_id", int'(next_id), int'(o_new_cmt_id));
    id             = next_id;
    i_disp_valid   = 1'b1;
    i_disp_grp_id  = grp;
    i_disp_pc      = pc;
    i_disp_illegal = illegal;
    tick();
    i_disp_valid   = 1'b0;
    i_disp_grp_id  = '0;
    i_disp_pc      = '0;
    i_disp_illegal = '0;
    next_id        = next_id + 1'b1;
  endtask

  task automatic report_one(input int port, input logic [CMT_ID_W-1:0] id,
                            input logic [LANE_W-1:0] lane, input logic kind,
                            input logic exc, input rpt_info_u info);
    i_done_valid[port]  = 1'b1;
    i_done_cmt_id[port] = id;
    i_done_lane[port]   = lane;
    i_done_kind[port]   = kind;
    i_done_exc[port]    = exc;
    i_done_info[port]   = info;
    tick();
    clear_reports();
  endtask

  // plain done for every valid lane on the port of the same number
  task automatic report_group(input logic [CMT_ID_W-1:0] id, input logic [DISP_SIZE-1:0] grp);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (grp[d]) begin
        i_done_valid[d]  = 1'b1;
        i_done_cmt_id[d] = id;
        i_done_lane[d]   = LANE_W'(d);
      end
    end
    tick();
    clear_reports();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      tick();
    end
  endtask

  // commit outputs settle mid-cycle
  always @(negedge i_clk) begin
    if (i_reset_n && o_cmt_valid) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("%s: group %0d committed while no commit was expected", cur_test, o_cmt_id);
      end
      if (exp_q.size() != 0) begin
        compare_commit(exp_q.pop_front());
      end
    end
  end

  task automatic compare_commit(input commit_t e);
    check_val("cmt_id", int'(e.id), int'(o_cmt_id));
    check_val("grp_id", int'(e.grp), int'(o_cmt_grp_id));
    check_val("dead_id", int'(e.dead), int'(o_cmt_dead_id));
    check_val("except_valid", int'(e.exc), int'(o_cmt_except_valid));
    check_val("flush", int'(e.flush), int'(o_cmt_flush));
    check_val("redirect_pc", int'(e.redirect), int'(o_cmt_redirect_pc));
    if (e.exc != '0) begin
      check_val("except_cause", int'(e.cause), int'(o_cmt_except_cause));
      check_val("tval", int'(e.tval), int'(o_cmt_tval));
      check_val("epc", int'(e.epc), int'(o_cmt_epc));
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_in_order();
    logic [CMT_ID_W-1:0] ids [4];
    cur_test = "in_order";
    for (int g = 0; g < 4; g++) begin
      dispatch(2'b11, rand_pc(), 2'b00, ids[g]);
      exp_q.push_back(plain_commit(ids[g], 2'b11, 2'b00));
    end
    for (int g = 3; g >= 0; g--) begin  // youngest first
      report_one(g % 2, ids[g], LANE_W'(1), 1'b0, 1'b0, '0);
      report_one(g % 2, ids[g], LANE_W'(0), 1'b0, 1'b0, '0);
    end
    wait_drain();
  endtask

  task automatic test_illegal();
    commit_t             e;
    logic [PC_W-1:0]     pc;
    logic [CMT_ID_W-1:0] id;
    cur_test = "illegal";
    pc = rand_pc();
    dispatch(2'b11, pc, 2'b10, id);
    e       = plain_commit(id, 2'b11, 2'b00);
    e.exc   = 2'b10;
    e.cause = CAUSE_ILLEGAL;
    e.epc   = pc + PC_W'(LANE_BYTES);
    e.flush = 1'b1;
    exp_q.push_back(e);
    report_one(0, id, LANE_W'(0), 1'b0, 1'b0, '0);
    wait_drain();
  endtask

  task automatic test_reported_exc();
    commit_t             e;
    rpt_info_u           info;
    logic [PC_W-1:0]     pc;
    logic [CMT_ID_W-1:0] id;
    cur_test = "reported_exc";
    pc = rand_pc();
    dispatch(2'b11, pc, 2'b00, id);
    info           = '0;
    info.exc.cause = CAUSE_W'($random(seed));
    info.exc.tval  = TVAL_W'($random(seed));
    e       = plain_commit(id, 2'b11, 2'b10);
    e.exc   = 2'b01;
    e.cause = info.exc.cause;
    e.tval  = info.exc.tval;
    e.epc   = pc;
    e.flush = 1'b1;
    exp_q.push_back(e);
    report_one(1, id, LANE_W'(0), 1'b0, 1'b1, info);
    report_one(0, id, LANE_W'(1), 1'b0, 1'b0, '0);
    wait_drain();
  endtask

  task automatic test_mispredict();
    commit_t             e;
    rpt_info_u           info;
    logic [CMT_ID_W-1:0] id;
    cur_test = "mispredict";
    dispatch(2'b11, rand_pc(), 2'b00, id);
    info               = '0;
    info.br.mispredict = 1'b1;
    info.br.taken      = 1'b1;
    info.br.target     = TGT_W'($random(seed));
    e          = plain_commit(id, 2'b11, 2'b10);
    e.flush    = 1'b1;
    e.redirect = PC_W'(info.br.target * 2);  // target counts halfwords
    exp_q.push_back(e);
    report_one(0, id, LANE_W'(0), 1'b1, 1'b0, info);
    report_one(1, id, LANE_W'(1), 1'b0, 1'b0, '0);
    wait_drain();
  endtask

  task automatic test_flush_drain();
    commit_t             e;
    logic [PC_W-1:0]     pc;
    logic [CMT_ID_W-1:0] id_a;
    logic [CMT_ID_W-1:0] id_b;
    logic [CMT_ID_W-1:0] id_c;
    logic [CMT_ID_W-1:0] id_d;
    cur_test = "flush_drain";
    pc = rand_pc();
    dispatch(2'b11, pc, 2'b10, id_a);
    e       = plain_commit(id_a, 2'b11, 2'b00);
    e.exc   = 2'b10;
    e.cause = CAUSE_ILLEGAL;
    e.epc   = pc + PC_W'(LANE_BYTES);
    e.flush = 1'b1;
    exp_q.push_back(e);
    // younger groups die with the flush and need no reports
    dispatch(2'b11, rand_pc(), 2'b00, id_b);
    exp_q.push_back(plain_commit(id_b, 2'b11, 2'b11));
    dispatch(2'b01, rand_pc(), 2'b00, id_c);
    exp_q.push_back(plain_commit(id_c, 2'b01, 2'b01));
    report_one(0, id_a, LANE_W'(0), 1'b0, 1'b0, '0);
    wait_drain();
    dispatch(2'b11, rand_pc(), 2'b00, id_d);
    exp_q.push_back(plain_commit(id_d, 2'b11, 2'b00));
    report_group(id_d, 2'b11);
    wait_drain();
  endtask

  task automatic test_full_wrap();
    logic [CMT_ID_W-1:0]  ids  [ROB_ENTRIES];
    logic [DISP_SIZE-1:0] grps [ROB_ENTRIES];
    cur_test = "full_wrap";
    for (int lap = 0; lap < 3; lap++) begin
      for (int g = 0; g < ROB_ENTRIES; g++) begin
        grps[g] = DISP_SIZE'({$random(seed)} % 3 + 1);  // any nonzero lane mask
        dispatch(grps[g], rand_pc(), 2'b00, ids[g]);
        exp_q.push_back(plain_commit(ids[g], grps[g], 2'b00));
      end
      // same slots, other generation
      for (int g = 0; g < ROB_ENTRIES; g++) begin
        report_group(ids[g] ^ CMT_ID_W'(ROB_ENTRIES), grps[g]);
      end
      check_val("pending commits", ROB_ENTRIES, exp_q.size());
      for (int g = ROB_ENTRIES - 1; g >= 0; g--) begin
        report_group(ids[g], grps[g]);
      end
      wait_drain();
    end
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    seed           = 10;
    errors         = 0;
    checks         = 0;
    next_id        = '0;
    cur_test       = "reset";
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_disp_grp_id  = '0;
    i_disp_pc      = '0;
    i_disp_illegal = '0;
    clear_reports();
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_reset_n = 1'b1;
    check_val("cmt_valid", 0, int'(o_cmt_valid));
    check_val("cmt_flush", 0, int'(o_cmt_flush));
    check_val("except_valid", 0, int'(o_cmt_except_valid));
    check_val("new_cmt_id", 0, int'(o_new_cmt_id));
    check_val("cmt_id", 0, int'(o_cmt_id));
    tick();
    test_in_order();
    test_illegal();
    test_reported_exc();
    test_mispredict();
    test_flush_drain();
    test_full_wrap();
    tick();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles in test %s", cycles, cur_test);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: src.f
logic/rob_pkg.sv
logic/rob_ifs.sv
logic/rob_alloc.sv
logic/rob_entry.sv
logic/rob_commit.sv
logic/rob_top.sv
test/rob_checker.sv
test/rob_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module rob_tb -o rob_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rob_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log && exit 0 || exit 1
